// ==== spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  // Command format
  localparam int CMD_WIDTH  = 12;
  localparam int ADDR_WIDTH = 3;
  localparam int DATA_WIDTH = 8;

  // Only the flag and the address go out before a read
  localparam int HDR_BITS = 1 + ADDR_WIDTH;

  // SPI timing in clk cycles
  localparam int SCLK_HALF   = 4;  // Half period of sclk
  localparam int TURN_CYCLES = 16; // cs high between read header and read data

  // Counter widths derived from the values above
  localparam int BIT_CNT_WIDTH = $clog2(CMD_WIDTH + 1);
  localparam int PHASE_WIDTH   = $clog2((TURN_CYCLES > SCLK_HALF) ? TURN_CYCLES : SCLK_HALF);

  // Bit 11 is the write flag, bits 10:8 the address, bits 7:0 the data
  typedef struct packed {
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } spi_cmd_t;

  // One frame as the engine sends it
  typedef struct packed {
    logic                     is_read;  // Header only, data phase follows
    logic [CMD_WIDTH-1:0]     tx_bits;  // Left-aligned, MSB leaves first
    logic [BIT_CNT_WIDTH-1:0] tx_count; // Bits to send from tx_bits
  } spi_plan_t;

endpackage

// ==== pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_vld,
  input  T     in_data,
  output logic in_rdy,
  output logic out_vld,
  output T     out_data,
  input  logic out_rdy
);

  // The slot frees up in the same cycle its entry is taken downstream
  assign in_rdy = !out_vld || out_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_vld <= 1'b0;
    end
    else if (in_vld && in_rdy)
    begin
      out_vld <= 1'b1;
    end
    else if (out_rdy)
    begin
      out_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_vld && in_rdy)
    begin
      out_data <= in_data;
    end
  end

  // A stalled entry must hold still until the consumer takes it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_vld && !out_rdy) |=> (out_vld && $stable(out_data))
  );

endmodule

// ==== spi_cmd_decode.sv ====
`timescale 1ns/1ps

module spi_cmd_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_vld,
  input  spi_cmd_pkg::spi_cmd_t cmd,
  output logic                  cmd_rdy,
  output logic                  plan_vld,
  output spi_cmd_pkg::spi_plan_t plan,
  input  logic                  plan_rdy
);

  import spi_cmd_pkg::*;

  spi_plan_t next_plan;

  // A write goes out whole and a read only sends its header
  always_comb
  begin
    next_plan.is_read = !cmd.write;
    if (cmd.write)
    begin
      next_plan.tx_bits  = cmd;
      next_plan.tx_count = BIT_CNT_WIDTH'(CMD_WIDTH);
    end
    else
    begin
      next_plan.tx_bits  = {cmd.write, cmd.addr, {DATA_WIDTH{1'b0}}};
      next_plan.tx_count = BIT_CNT_WIDTH'(HDR_BITS);
    end
  end

  assign cmd_rdy = !plan_vld || plan_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      plan_vld <= 1'b0;
    end
    else if (cmd_vld && cmd_rdy)
    begin
      plan_vld <= 1'b1;
    end
    else if (plan_rdy)
    begin
      plan_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      plan <= next_plan;
    end
  end

endmodule

// ==== spi_frame_engine.sv ====
`timescale 1ns/1ps

module spi_frame_engine (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   plan_vld,
  input  spi_cmd_pkg::spi_plan_t plan,
  output logic                   plan_rdy,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso,
  output logic                   read_vld,
  output logic [spi_cmd_pkg::DATA_WIDTH-1:0] read_data
);

  import spi_cmd_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SHIFT_OUT,
    ST_TURN,
    ST_SHIFT_IN,
    ST_FINISH
  } state_t;

  state_t                   state;
  logic [PHASE_WIDTH-1:0]   ph_cnt;
  logic [BIT_CNT_WIDTH-1:0] bit_cnt;
  logic [BIT_CNT_WIDTH-1:0] n_bits;   // Length of the current cs-low window
  logic                     is_read;
  logic [CMD_WIDTH-1:0]     tx_sr;
  logic [DATA_WIDTH-1:0]    rx_sr;

  logic start;
  logic shifting;
  logic ph_done;
  logic sclk_rise;
  logic sclk_fall;
  logic last_bit;
  logic turn_done;

  assign plan_rdy = (state == ST_IDLE);
  assign start    = plan_vld && plan_rdy;
  assign shifting = (state == ST_SHIFT_OUT) || (state == ST_SHIFT_IN);

  // The phase counter marks every sclk half period
  assign ph_done   = (ph_cnt == PHASE_WIDTH'(SCLK_HALF - 1));
  assign sclk_rise = shifting && ph_done && !sclk;
  assign sclk_fall = shifting && ph_done && sclk;
  assign last_bit  = ((bit_cnt + BIT_CNT_WIDTH'(1)) == n_bits);

  // The same counter measures the cs-high gap of a read
  assign turn_done = (state == ST_TURN) && (ph_cnt == PHASE_WIDTH'(TURN_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      cs       <= 1'b1;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      ph_cnt   <= '0;
      bit_cnt  <= '0;
      n_bits   <= '0;
      is_read  <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            state   <= ST_SHIFT_OUT;
            cs      <= 1'b0;
            mosi    <= plan.tx_bits[CMD_WIDTH-1]; // First bit is set up while sclk is low
            ph_cnt  <= '0;
            bit_cnt <= '0;
            n_bits  <= plan.tx_count;
            is_read <= plan.is_read;
          end
        end
        ST_SHIFT_OUT, ST_SHIFT_IN:
        begin
          if (ph_done)
          begin
            ph_cnt <= '0;
            sclk   <= !sclk;
            if (sclk_fall)
            begin
              bit_cnt <= bit_cnt + BIT_CNT_WIDTH'(1);
              if (last_bit)
              begin
                cs      <= 1'b1; // Same edge as the last sclk fall
                mosi    <= 1'b0;
                bit_cnt <= '0;
                if (state == ST_SHIFT_IN)
                begin
                  read_vld <= 1'b1;
                  state    <= ST_FINISH;
                end
                else if (is_read)
                begin
                  state <= ST_TURN;
                end
                else
                begin
                  state <= ST_FINISH;
                end
              end
              else if (state == ST_SHIFT_OUT)
              begin
                mosi <= tx_sr[CMD_WIDTH-1];
              end
            end
          end
          else
          begin
            ph_cnt <= ph_cnt + PHASE_WIDTH'(1);
          end
        end
        ST_TURN:
        begin
          if (turn_done)
          begin
            state  <= ST_SHIFT_IN;
            cs     <= 1'b0;
            ph_cnt <= '0;
            n_bits <= BIT_CNT_WIDTH'(DATA_WIDTH);
          end
          else
          begin
            ph_cnt <= ph_cnt + PHASE_WIDTH'(1);
          end
        end
        // One idle cycle with cs high before the next plan
        ST_FINISH:
        begin
          state <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Shift registers for outgoing and incoming bits
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      tx_sr <= plan.tx_bits << 1;
    end
    else if (sclk_fall && (state == ST_SHIFT_OUT))
    begin
      tx_sr <= tx_sr << 1;
    end
    if (sclk_rise && (state == ST_SHIFT_IN))
    begin
      rx_sr <= {rx_sr[DATA_WIDTH-2:0], miso}; // MSB arrives first
    end
  end

  assign read_data = rx_sr; // Settled while read_vld is high

  a_sclk_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    cs |-> !sclk
  );

  a_read_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld
  );

endmodule

// ==== spi_cmd_master.sv ====
`timescale 1ns/1ps

module spi_cmd_master (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_vld,
  input  spi_cmd_pkg::spi_cmd_t cmd_in,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [spi_cmd_pkg::DATA_WIDTH-1:0] read_data
);

  import spi_cmd_pkg::*;

  logic      dec_vld;
  spi_cmd_t  dec_cmd;
  logic      dec_rdy;
  logic      plan_vld;
  spi_plan_t plan;
  logic      plan_rdy;

  // Input slot, so one more command can wait while the decoder is full
  pipe_reg #(
    .T(spi_cmd_t)
  ) cmd_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_vld   (cmd_vld),
    .in_data  (cmd_in),
    .in_rdy   (cmd_rdy),
    .out_vld  (dec_vld),
    .out_data (dec_cmd),
    .out_rdy  (dec_rdy)
  );

  spi_cmd_decode decode_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (dec_vld),
    .cmd      (dec_cmd),
    .cmd_rdy  (dec_rdy),
    .plan_vld (plan_vld),
    .plan     (plan),
    .plan_rdy (plan_rdy)
  );

  spi_frame_engine engine_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .plan_vld  (plan_vld),
    .plan      (plan),
    .plan_rdy  (plan_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  // Reset spans the first two rising edges and is released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== tb_spi_slave.sv ====
`timescale 1ns/1ps

module tb_spi_slave (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             sclk,
  input  logic                             cs,
  input  logic                             mosi,
  output logic                             miso,
  output logic                             win_vld,
  output int                               win_len,
  output logic [spi_cmd_pkg::CMD_WIDTH-1:0] win_bits,
  output int                               win_gap
);

  import spi_cmd_pkg::*;

  logic [DATA_WIDTH-1:0] regs [2**ADDR_WIDTH];
  logic                  sclk_q;
  logic                  cs_q;
  logic [CMD_WIDTH-1:0]  rx_sr;
  int                    bit_cnt;
  logic                  rd_armed; // A header came in, the next window returns data
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] tx_sr;
  int                    gap;

  // Bus edges are found by sampling sclk and cs on every clk edge
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int a = 0; a < 2**ADDR_WIDTH; a++)
        regs[a] <= 8'hA0 + DATA_WIDTH'(a);
      sclk_q   <= 1'b0;
      cs_q     <= 1'b1;
      miso     <= 1'b0;
      win_vld  <= 1'b0;
      win_len  <= 0;
      win_bits <= '0;
      win_gap  <= 0;
      rx_sr    <= '0;
      bit_cnt  <= 0;
      rd_armed <= 1'b0;
      rd_addr  <= '0;
      tx_sr    <= '0;
      gap      <= 0;
    end
    else
    begin
      sclk_q  <= sclk;
      cs_q    <= cs;
      win_vld <= 1'b0;
      if (cs_q && !cs)
      begin
        rx_sr   <= '0;
        bit_cnt <= 0;
        if (rd_armed)
        begin
          tx_sr <= regs[rd_addr];
          miso  <= regs[rd_addr][DATA_WIDTH-1]; // First data bit ready before the first rise
        end
      end
      else if (!cs && sclk && !sclk_q)
      begin
        rx_sr   <= {rx_sr[CMD_WIDTH-2:0], mosi};
        bit_cnt <= bit_cnt + 1;
      end
      else if (!cs && !sclk && sclk_q && rd_armed)
      begin
        miso  <= tx_sr[DATA_WIDTH-2];
        tx_sr <= tx_sr << 1;
      end
      else if (cs && !cs_q)
      begin
        win_vld  <= 1'b1;
        win_len  <= bit_cnt;
        win_bits <= rx_sr;
        win_gap  <= gap;
        miso     <= 1'b0;
        if (bit_cnt == CMD_WIDTH && rx_sr[CMD_WIDTH-1])
          regs[rx_sr[CMD_WIDTH-2 -: ADDR_WIDTH]] <= rx_sr[DATA_WIDTH-1:0];
        if (bit_cnt == HDR_BITS)
        begin
          rd_armed <= 1'b1;
          rd_addr  <= rx_sr[ADDR_WIDTH-1:0];
          gap      <= 1;
        end
        else
        begin
          rd_armed <= 1'b0;
        end
      end
      else if (cs && rd_armed)
      begin
        gap <= gap + 1; // Turnaround measured in clk cycles with cs high
      end
    end
  end

endmodule

// ==== tb_spi_cmd_master.sv ====
`timescale 1ns/1ps

module tb_spi_cmd_master;

  import spi_cmd_pkg::*;

  localparam int N_FIRST    = 4;  // Reads issued before any write
  localparam int N_MIXED    = 60;
  localparam int N_CMDS     = N_FIRST + N_MIXED;
  localparam int BIT_CYCLES = 2 * SCLK_HALF;
  localparam int FRAME_MAX  = CMD_WIDTH * BIT_CYCLES + TURN_CYCLES
                              + DATA_WIDTH * BIT_CYCLES + 20;
  localparam int LIMIT      = N_CMDS * FRAME_MAX + 200;

  typedef enum logic [1:0] {WIN_WRITE, WIN_HDR, WIN_DATA} win_kind_t;

  typedef struct packed {
    win_kind_t            kind;
    logic [CMD_WIDTH-1:0] bits;
  } win_exp_t;

  typedef struct packed {
    logic                  untouched;
    logic [DATA_WIDTH-1:0] data;
  } rd_exp_t;

  logic                  clk;
  logic                  rst_n;
  logic                  cmd_vld;
  spi_cmd_t              cmd_in;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [DATA_WIDTH-1:0] read_data;
  logic                  win_vld;
  int                    win_len;
  int                    win_gap;
  logic [CMD_WIDTH-1:0]  win_bits;

  // Reference register file that follows the acceptance order
  logic [DATA_WIDTH-1:0]    model_regs [2**ADDR_WIDTH];
  logic [2**ADDR_WIDTH-1:0] touched;
  win_exp_t                 exp_win [$];
  rd_exp_t                  exp_rd [$];
  logic                     stall_seen;
  int n_writes, n_reads, n_windows, n_pulses;
  int err_reset, err_write, err_hdr, err_raw, err_untouched, err_turn, err_flow;
  int chk_write, chk_hdr, chk_raw, chk_untouched, chk_turn;
  int tests_run, tests_failed;
  int cycles = 0;

  tb_clk_gen clk_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spi_cmd_master spi_cmd_master_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd_in    (cmd_in),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  tb_spi_slave slave_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso),
    .win_vld  (win_vld),
    .win_len  (win_len),
    .win_bits (win_bits),
    .win_gap  (win_gap)
  );

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task check_window;
    win_exp_t e;
    n_windows++;
    if (exp_win.size() == 0)
    begin
      $display("SPI window of %0d bits arrived with no command waiting for it", win_len);
      err_flow++;
    end
    else
    begin
      e = exp_win.pop_front();
      case (e.kind)
        WIN_WRITE:
        begin
          chk_write++;
          if (win_len != CMD_WIDTH || win_bits != e.bits)
          begin
            $display("Mismatch write_frames: expected %0d bits %h, actual %0d bits %h",
                     CMD_WIDTH, e.bits, win_len, win_bits);
            err_write++;
          end
        end
        WIN_HDR:
        begin
          chk_hdr++;
          if (win_len != HDR_BITS || win_bits != e.bits)
          begin
            $display("Mismatch read_header: expected %0d bits %h, actual %0d bits %h",
                     HDR_BITS, e.bits, win_len, win_bits);
            err_hdr++;
          end
        end
        default:
        begin
          chk_turn++;
          if (win_len != DATA_WIDTH || win_gap != TURN_CYCLES)
          begin
            $display("Mismatch turnaround: expected gap %0d, %0d bits, actual gap %0d, %0d bits",
                     TURN_CYCLES, DATA_WIDTH, win_gap, win_len);
            err_turn++;
          end
        end
      endcase
    end
  endtask

  task check_read;
    rd_exp_t e;
    n_pulses++;
    if (exp_rd.size() == 0)
    begin
      $display("read_vld pulsed with no read outstanding");
      err_flow++;
    end
    else
    begin
      e = exp_rd.pop_front();
      if (e.untouched)
        chk_untouched++;
      else
        chk_raw++;
      if (read_data != e.data)
      begin
        $display("Mismatch %s: expected %h, actual %h",
                 e.untouched ? "read_untouched" : "read_after_write", e.data, read_data);
        if (e.untouched)
          err_untouched++;
        else
          err_raw++;
      end
    end
  endtask

  // Outputs are settled at the falling edge and the monitors look there before new inputs go out
  task tick;
    @(negedge clk);
    if (win_vld)
      check_window();
    if (read_vld)
      check_read();
  endtask

  task check_reset_value(input string sig, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("Mismatch reset_state: %s expected %b, actual %b", sig, expected, actual);
      err_reset++;
    end
  endtask

  task report_test(input string name, input int errs, input int checked);
    tests_run++;
    if (checked == 0)
    begin
      $display("FAIL %s: the random sequence never exercised this case", name);
      tests_failed++;
    end
    else if (errs != 0)
    begin
      $display("FAIL %s: %0d of %0d checks wrong", name, errs, checked);
      tests_failed++;
    end
    else
    begin
      $display("PASS %s: %0d checks", name, checked);
    end
  endtask

  function automatic spi_cmd_t rand_cmd(input logic allow_write);
    spi_cmd_t c;
    c.write = allow_write && ($urandom_range(0, 9) < 6);
    c.addr  = ADDR_WIDTH'($urandom_range(0, 2**ADDR_WIDTH - 1));
    c.data  = DATA_WIDTH'($urandom());
    return c;
  endfunction

  task record_cmd(input spi_cmd_t c);
    win_exp_t w;
    rd_exp_t  r;
    if (c.write)
    begin
      n_writes++;
      model_regs[c.addr] = c.data;
      touched[c.addr]    = 1'b1;
      w.kind = WIN_WRITE;
      w.bits = c;
      exp_win.push_back(w);
    end
    else
    begin
      n_reads++;
      w.kind = WIN_HDR;
      w.bits = CMD_WIDTH'({c.write, c.addr});
      exp_win.push_back(w);
      w.kind = WIN_DATA;
      w.bits = '0;
      exp_win.push_back(w);
      r.untouched = !touched[c.addr];
      r.data      = model_regs[c.addr];
      exp_rd.push_back(r);
    end
  endtask

  // cmd_rdy only moves on a rising edge, so its value now decides the next transfer
  task send_cmd(input spi_cmd_t c);
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      stall_seen = 1'b1;
      tick();
    end
    record_cmd(c);
    tick();
    cmd_vld = 1'b0;
  endtask

  initial
  begin
    cmd_vld    = 1'b0;
    cmd_in     = '0;
    touched    = '0;
    stall_seen = 1'b0;
    void'($urandom(32));
    for (int a = 0; a < 2**ADDR_WIDTH; a++)
      model_regs[a] = 8'hA0 + DATA_WIDTH'(a);

    @(posedge rst_n);
    tick();
    check_reset_value("cs", cs, 1'b1);
    check_reset_value("sclk", sclk, 1'b0);
    check_reset_value("mosi", mosi, 1'b0);
    check_reset_value("read_vld", read_vld, 1'b0);
    check_reset_value("cmd_rdy", cmd_rdy, 1'b1);
    report_test("reset_state", err_reset, 5);

    for (int i = 0; i < N_CMDS; i++)
    begin
      send_cmd(rand_cmd(i >= N_FIRST));
      repeat ($urandom_range(0, 3)) tick();
    end
    while (exp_win.size() != 0 || exp_rd.size() != 0)
      tick();
    repeat (FRAME_MAX) tick(); // A duplicated frame would still show up here

    if (n_pulses != n_reads)
    begin
      $display("Mismatch flow: expected %0d read_vld pulses, actual %0d", n_reads, n_pulses);
      err_flow++;
    end
    if (n_windows != n_writes + 2 * n_reads)
    begin
      $display("Mismatch flow: expected %0d SPI windows, actual %0d",
               n_writes + 2 * n_reads, n_windows);
      err_flow++;
    end
    if (!stall_seen)
    begin
      $display("cmd_rdy never went low while the command queue was full");
      err_flow++;
    end

    report_test("write_frames", err_write, chk_write);
    report_test("read_header", err_hdr, chk_hdr);
    report_test("read_after_write", err_raw, chk_raw);
    report_test("read_untouched", err_untouched, chk_untouched);
    report_test("turnaround", err_turn, chk_turn);
    report_test("flow", err_flow, 3);
    $display("Summary: %0d tests, %0d passed, %0d failed (%0d writes, %0d reads)",
             tests_run, tests_run - tests_failed, tests_failed, n_writes, n_reads);
    if (tests_failed == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== spi_cmd_master.f ====
spi_cmd_pkg.sv
pipe_reg.sv
spi_cmd_decode.sv
spi_frame_engine.sv
spi_cmd_master.sv
tb_clk_gen.sv
tb_spi_slave.sv
tb_spi_cmd_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_spi_cmd_master
FILELIST  ?= spi_cmd_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
